// ==== include/ppu_mmr_settings.svh ====
`ifndef PPU_MMR_SETTINGS_SVH
`define PPU_MMR_SETTINGS_SVH

// cpu bus, word addressed on addr[5:1]
`define MMR_DATA_W          16
`define MMR_ADDR_W          5

// board configuration string, shifted in one byte per write
`define MMR_CFG_W           8
`define MMR_CFG_BYTES       21

// programmable cps-b functions, one address byte each
`define MMR_CPSB_SLOTS      11

// palette pages that the copy engine may transfer
`define MMR_PAL_PAGES       6

// value returned for address 31 and unmapped cps-b reads
`define MMR_UNMAPPED        16'hffff

// layer order 3,2,1,0 from the top field down, no layer enables
`define MMR_LAYER_CTRL_RST  16'h1c80

`endif

// ==== src/ppu_mmr_pkg.sv ====
`include "ppu_mmr_settings.svh"

package ppu_mmr_pkg;

    // one cpu access, dsn bits are active low byte strobes
    typedef struct packed {
        logic [`MMR_ADDR_W-1:0] addr;
        logic [1:0]             dsn;
        logic [`MMR_DATA_W-1:0] data;
    } cpu_bus_t;

    // cps-a word addresses, 0x00 up to 0x11 in order
    typedef enum logic [`MMR_ADDR_W-1:0] {
        OBJ_BASE = 5'h00, SCR1_BASE, SCR2_BASE, SCR3_BASE,
        ROW_BASE, PAL_BASE, HPOS1, VPOS1, HPOS2, VPOS2, HPOS3, VPOS3,
        HSTAR1, VSTAR1, HSTAR2, VSTAR2, STAR_BASE, PPU_CTRL
    } cpsa_reg_e;

    // cps-b functions in the order of the configuration string
    typedef enum logic [3:0] {
        ID, MULT1, MULT2, RSLT0, RSLT1, LAYER,
        PRIO0, PRIO1, PRIO2, PRIO3, PAL_PAGE
    } cpsb_slot_e;

    typedef struct packed {
        logic [`MMR_CPSB_SLOTS-1:0][`MMR_ADDR_W-1:0] slot;
        logic [7:0]                                  id;   // 16-bit id packed into nibbles
    } cpsb_map_t;

    typedef struct packed {
        logic [3:0][7:0] layer_mask;
        logic [5:0]      game;
        logic [15:0]     bank_offset;
        logic [15:0]     bank_mask;
    } board_cfg_t;

    typedef struct packed {
        logic [`MMR_DATA_W-1:0] hpos1, hpos2, hpos3;
        logic [`MMR_DATA_W-1:0] vpos1, vpos2, vpos3;
        logic [`MMR_DATA_W-1:0] hstar1, hstar2, vstar1, vstar2;
    } scroll_set_t;

    typedef struct packed {
        logic [`MMR_DATA_W-1:0] obj, scr1, scr2, scr3, row, star;
        logic [`MMR_DATA_W-1:0] pal_base;
        logic [`MMR_DATA_W-1:0] ppu_ctrl;
    } vram_set_t;

    typedef struct packed {
        logic [`MMR_DATA_W-1:0]   layer_ctrl;
        logic [`MMR_DATA_W-1:0]   prio0, prio1, prio2, prio3;
        logic [`MMR_PAL_PAGES-1:0] pal_page_en;
    } prio_set_t;

    typedef enum logic {
        COPY_IDLE,
        COPY_ARMED
    } copy_state_e;

endpackage

// ==== src/cpsb_map_loader.sv ====
`timescale 1ns/100ps
`include "ppu_mmr_settings.svh"

module cpsb_map_loader (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      cfg_we,
    input  logic [`MMR_CFG_W-1:0]     cfg_data,
    output ppu_mmr_pkg::cpsb_map_t    map,
    output ppu_mmr_pkg::board_cfg_t   board
);

    // byte 0 holds the newest write, byte 20 the oldest
    logic [`MMR_CFG_BYTES-1:0][`MMR_CFG_W-1:0] cfg_bytes;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            // all ones parks every slot at address 31
            cfg_bytes <= '1;
        end else if (cfg_we) begin
            cfg_bytes <= {cfg_bytes[`MMR_CFG_BYTES-2:0], cfg_data};
        end
    end

    // slot addresses are byte addresses, keep the word part only
    always_comb begin
        map.id = cfg_bytes[1];
        map.slot[ppu_mmr_pkg::ID] = cfg_bytes[0][`MMR_ADDR_W:1];
        // the remaining slots follow the id byte
        for (int s = 1; s < `MMR_CPSB_SLOTS; s++) begin
            map.slot[s] = cfg_bytes[s + 1][`MMR_ADDR_W:1];
        end
    end

    // layer masks in bytes 12 to 15
    always_comb begin
        for (int m = 0; m < 4; m++) begin
            board.layer_mask[m] = cfg_bytes[12 + m];
        end
    end

    assign board.game        = cfg_bytes[16][5:0];
    // rom banking, high byte sits above the low one
    assign board.bank_offset = {cfg_bytes[18], cfg_bytes[17]};
    assign board.bank_mask   = {cfg_bytes[20], cfg_bytes[19]};

endmodule

// ==== src/cpsa_regs.sv ====
`timescale 1ns/100ps
`include "ppu_mmr_settings.svh"

module cpsa_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      ppu1_cs,
    input  ppu_mmr_pkg::cpu_bus_t     bus,
    output ppu_mmr_pkg::scroll_set_t  scroll,
    output ppu_mmr_pkg::vram_set_t    vram,
    output logic                      pal_copy
);

    ppu_mmr_pkg::cpsa_reg_e   reg_sel;
    ppu_mmr_pkg::copy_state_e copy_state;
    logic                     pal_wr;

    // replace only the bytes whose strobe is low
    function automatic logic [`MMR_DATA_W-1:0] merge_bytes(
        input logic [`MMR_DATA_W-1:0] old_word,
        input logic [`MMR_DATA_W-1:0] new_word,
        input logic [1:0]             dsn
    );
        logic [`MMR_DATA_W-1:0] result;
        result = old_word;
        if (!dsn[1]) begin
            result[15:8] = new_word[15:8];
        end
        if (!dsn[0]) begin
            result[7:0] = new_word[7:0];
        end
        return result;
    endfunction

    assign reg_sel = ppu_mmr_pkg::cpsa_reg_e'(bus.addr);
    assign pal_wr  = ppu1_cs && (reg_sel == ppu_mmr_pkg::PAL_BASE);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            scroll <= '0;
            vram   <= '0;
        end else if (ppu1_cs) begin
            case (reg_sel)
                ppu_mmr_pkg::OBJ_BASE:  vram.obj      <= merge_bytes(vram.obj, bus.data, bus.dsn);
                ppu_mmr_pkg::SCR1_BASE: vram.scr1     <= merge_bytes(vram.scr1, bus.data, bus.dsn);
                ppu_mmr_pkg::SCR2_BASE: vram.scr2     <= merge_bytes(vram.scr2, bus.data, bus.dsn);
                ppu_mmr_pkg::SCR3_BASE: vram.scr3     <= merge_bytes(vram.scr3, bus.data, bus.dsn);
                ppu_mmr_pkg::ROW_BASE:  vram.row      <= merge_bytes(vram.row, bus.data, bus.dsn);
                ppu_mmr_pkg::PAL_BASE:  vram.pal_base <= merge_bytes(vram.pal_base, bus.data,
                                                                     bus.dsn);
                ppu_mmr_pkg::HPOS1:     scroll.hpos1  <= merge_bytes(scroll.hpos1, bus.data, bus.dsn);
                ppu_mmr_pkg::VPOS1:     scroll.vpos1  <= merge_bytes(scroll.vpos1, bus.data, bus.dsn);
                ppu_mmr_pkg::HPOS2:     scroll.hpos2  <= merge_bytes(scroll.hpos2, bus.data, bus.dsn);
                ppu_mmr_pkg::VPOS2:     scroll.vpos2  <= merge_bytes(scroll.vpos2, bus.data, bus.dsn);
                ppu_mmr_pkg::HPOS3:     scroll.hpos3  <= merge_bytes(scroll.hpos3, bus.data, bus.dsn);
                ppu_mmr_pkg::VPOS3:     scroll.vpos3  <= merge_bytes(scroll.vpos3, bus.data, bus.dsn);
                ppu_mmr_pkg::HSTAR1:    scroll.hstar1 <= merge_bytes(scroll.hstar1, bus.data, bus.dsn);
                ppu_mmr_pkg::VSTAR1:    scroll.vstar1 <= merge_bytes(scroll.vstar1, bus.data, bus.dsn);
                ppu_mmr_pkg::HSTAR2:    scroll.hstar2 <= merge_bytes(scroll.hstar2, bus.data, bus.dsn);
                ppu_mmr_pkg::VSTAR2:    scroll.vstar2 <= merge_bytes(scroll.vstar2, bus.data, bus.dsn);
                ppu_mmr_pkg::STAR_BASE: vram.star     <= merge_bytes(vram.star, bus.data, bus.dsn);
                ppu_mmr_pkg::PPU_CTRL:  vram.ppu_ctrl <= merge_bytes(vram.ppu_ctrl, bus.data,
                                                                     bus.dsn);
                // 0x12 and up are outside cps-a
                default: ;
            endcase
        end
    end

    // the copy waits for the cpu to release the bus, so that
    // pal_base has its final value when the copy engine samples it
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            copy_state <= ppu_mmr_pkg::COPY_IDLE;
            pal_copy   <= 1'b0;
        end else begin
            pal_copy <= 1'b0;
            case (copy_state)
                ppu_mmr_pkg::COPY_IDLE: begin
                    if (pal_wr) begin
                        copy_state <= ppu_mmr_pkg::COPY_ARMED;
                    end
                end
                ppu_mmr_pkg::COPY_ARMED: begin
                    if (!ppu1_cs) begin
                        pal_copy   <= 1'b1;
                        copy_state <= ppu_mmr_pkg::COPY_IDLE;
                    end
                end
                default: copy_state <= ppu_mmr_pkg::COPY_IDLE;
            endcase
        end
    end

    // one pulse per armed write, never a stretched one
    a_copy_single: assert property (@(posedge clk) disable iff (reg_rst)
        pal_copy |=> !pal_copy)
        else $error("pal_copy high on two cycles in a row");

    a_copy_from_armed: assert property (@(posedge clk) disable iff (reg_rst)
        $rose(pal_copy) |-> $past(copy_state) == ppu_mmr_pkg::COPY_ARMED)
        else $error("pal_copy rose without an armed sequencer");

endmodule

// ==== src/cpsb_regs.sv ====
`timescale 1ns/100ps
`include "ppu_mmr_settings.svh"

module cpsb_regs (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  logic                     ppu2_cs,
    input  ppu_mmr_pkg::cpu_bus_t    bus,
    input  ppu_mmr_pkg::cpsb_map_t   map,
    output ppu_mmr_pkg::prio_set_t   prio,
    output logic [`MMR_DATA_W-1:0]   mmr_dout
);

    logic [`MMR_CPSB_SLOTS-1:0]                  slot_hit;
    logic [`MMR_CPSB_SLOTS-1:0]                  rd_sel;
    logic [`MMR_CPSB_SLOTS-1:0][`MMR_DATA_W-1:0] slot_val;
    logic [`MMR_DATA_W-1:0]                      rd_val;
    logic [`MMR_DATA_W-1:0]                      mult1;
    logic [`MMR_DATA_W-1:0]                      mult2;
    logic [2*`MMR_DATA_W-1:0]                    product;
    logic                                        wr_en;

    // address 31 is the parking spot of unused slots
    always_comb begin
        for (int s = 0; s < `MMR_CPSB_SLOTS; s++) begin
            slot_hit[s] = (bus.addr == map.slot[s]) && !(&bus.addr);
        end
    end

    // shared addresses read the lowest slot
    always_comb begin
        rd_sel = '0;
        for (int s = `MMR_CPSB_SLOTS - 1; s >= 0; s--) begin
            if (slot_hit[s]) begin
                rd_sel    = '0;
                rd_sel[s] = 1'b1;
            end
        end
    end

    always_comb begin
        slot_val = '0;
        // id nibbles land in the low half of each byte
        slot_val[ppu_mmr_pkg::ID]    = {4'd0, map.id[7:4], 4'd0, map.id[3:0]};
        slot_val[ppu_mmr_pkg::MULT1] = mult1;
        slot_val[ppu_mmr_pkg::MULT2] = mult2;
        slot_val[ppu_mmr_pkg::RSLT0] = product[`MMR_DATA_W-1:0];
        slot_val[ppu_mmr_pkg::RSLT1] = product[2*`MMR_DATA_W-1:`MMR_DATA_W];
        slot_val[ppu_mmr_pkg::LAYER] = prio.layer_ctrl;
        slot_val[ppu_mmr_pkg::PRIO0] = prio.prio0;
        slot_val[ppu_mmr_pkg::PRIO1] = prio.prio1;
        slot_val[ppu_mmr_pkg::PRIO2] = prio.prio2;
        slot_val[ppu_mmr_pkg::PRIO3] = prio.prio3;
        slot_val[ppu_mmr_pkg::PAL_PAGE][`MMR_PAL_PAGES-1:0] = prio.pal_page_en;
    end

    always_comb begin
        rd_val = `MMR_UNMAPPED;
        for (int s = 0; s < `MMR_CPSB_SLOTS; s++) begin
            if (rd_sel[s]) begin
                rd_val = slot_val[s];
            end
        end
    end

    // cps-b registers take full words only
    assign wr_en = ppu2_cs && (bus.dsn == 2'b00);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            prio.layer_ctrl  <= `MMR_LAYER_CTRL_RST;
            prio.prio0       <= '1;
            prio.prio1       <= '1;
            prio.prio2       <= '1;
            prio.prio3       <= '1;
            prio.pal_page_en <= '1;
            mult1            <= '0;
            mult2            <= '0;
        end else if (wr_en) begin
            if (slot_hit[ppu_mmr_pkg::MULT1]) begin
                mult1 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::MULT2]) begin
                mult2 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::LAYER]) begin
                prio.layer_ctrl <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::PRIO0]) begin
                prio.prio0 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::PRIO1]) begin
                prio.prio1 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::PRIO2]) begin
                prio.prio2 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::PRIO3]) begin
                prio.prio3 <= bus.data;
            end
            if (slot_hit[ppu_mmr_pkg::PAL_PAGE]) begin
                prio.pal_page_en <= bus.data[`MMR_PAL_PAGES-1:0];
            end
        end
    end

    // product trails the operands by one clock
    always_ff @(posedge clk) begin
        product <= mult1 * mult2;
    end

    // readback holds between cps-b accesses
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout <= `MMR_UNMAPPED;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_val;
        end
    end

    a_rd_onehot: assert property (@(posedge clk) disable iff (reg_rst)
        ppu2_cs |-> $onehot0(rd_sel))
        else $error("cps-b readback selects more than one slot");

endmodule

// ==== src/ppu_mmr.sv ====
`timescale 1ns/100ps
`include "ppu_mmr_settings.svh"

module ppu_mmr (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      ppu1_cs,
    input  logic                      ppu2_cs,
    input  ppu_mmr_pkg::cpu_bus_t     bus,
    input  logic                      cfg_we,
    input  logic [`MMR_CFG_W-1:0]     cfg_data,
    output ppu_mmr_pkg::scroll_set_t  scroll,
    output ppu_mmr_pkg::vram_set_t    vram,
    output ppu_mmr_pkg::prio_set_t    prio,
    output ppu_mmr_pkg::board_cfg_t   board,
    output logic                      pal_copy,
    output logic [`MMR_DATA_W-1:0]    mmr_dout
);

    // cps-b address map, internal to the block
    ppu_mmr_pkg::cpsb_map_t map;

    cpsb_map_loader u_loader (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map),
        .board    (board)
    );

    cpsa_regs u_cpsa (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .bus      (bus),
        .scroll   (scroll),
        .vram     (vram),
        .pal_copy (pal_copy)
    );

    cpsb_regs u_cpsb (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu2_cs  (ppu2_cs),
        .bus      (bus),
        .map      (map),
        .prio     (prio),
        .mmr_dout (mmr_dout)
    );

endmodule

// ==== verification/ppu_mmr_tb.sv ====
`timescale 1ns/100ps
`include "ppu_mmr_settings.svh"

module ppu_mmr_tb;

    localparam int N_CPSA = 400;
    localparam int N_CPSB = 400;
    localparam int N_MULT = 16;
    // covers 21 config writes and 800 accesses of up to four cycles each with margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic                     clk = 1'b0;
    logic                     reg_rst;
    logic                     ppu1_cs;
    logic                     ppu2_cs;
    logic                     cfg_we;
    logic [7:0]               cfg_data;
    ppu_mmr_pkg::cpu_bus_t    bus;
    ppu_mmr_pkg::scroll_set_t scroll;
    ppu_mmr_pkg::vram_set_t   vram;
    ppu_mmr_pkg::prio_set_t   prio;
    ppu_mmr_pkg::board_cfg_t  board;
    logic                     pal_copy;
    logic [15:0]              mmr_dout;

    // reference model
    logic [7:0]  m_cfg [21];
    logic [15:0] m_cpsa [18];
    logic [15:0] m_prio [4];
    logic [15:0] m_layer;
    logic [5:0]  m_pal_page;
    logic [15:0] m_mult1;
    logic [15:0] m_mult2;
    logic [31:0] m_product;
    logic [15:0] m_dout;
    logic        m_armed;
    logic        m_pal_copy;

    logic [4:0]  slot_pick [11];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          err_count;
    int          pulse_count;

    ppu_mmr uut (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .ppu2_cs  (ppu2_cs),
        .bus      (bus),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .scroll   (scroll),
        .vram     (vram),
        .prio     (prio),
        .board    (board),
        .pal_copy (pal_copy),
        .mmr_dout (mmr_dout)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [15:0] lcg_next16();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    // slot 0 sits in byte 0 and the other slots follow the id in byte 1
    function automatic logic [4:0] slot_addr(input int s);
        return (s == 0) ? m_cfg[0][5:1] : m_cfg[s + 1][5:1];
    endfunction

    function automatic logic [15:0] slot_value(input int s);
        case (s)
            0: return {4'h0, m_cfg[1][7:4], 4'h0, m_cfg[1][3:0]};
            1: return m_mult1;
            2: return m_mult2;
            3: return m_product[15:0];
            4: return m_product[31:16];
            5: return m_layer;
            10: return {10'd0, m_pal_page};
            default: return m_prio[s - 6];
        endcase
    endfunction

    // the lowest matching slot wins while 31 and unmatched addresses read all ones
    function automatic logic [15:0] read_value(input logic [4:0] addr);
        if (addr != 5'd31) begin
            for (int s = 0; s < 11; s++) begin
                if (slot_addr(s) == addr) begin
                    return slot_value(s);
                end
            end
        end
        return 16'hffff;
    endfunction

    task automatic abort_run();
        err_count++;
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_scroll(input ppu_mmr_pkg::scroll_set_t got,
                                input ppu_mmr_pkg::scroll_set_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: scroll got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vram(input ppu_mmr_pkg::vram_set_t got,
                              input ppu_mmr_pkg::vram_set_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: vram got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_prio(input ppu_mmr_pkg::prio_set_t got,
                              input ppu_mmr_pkg::prio_set_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: prio got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_board(input ppu_mmr_pkg::board_cfg_t got,
                               input ppu_mmr_pkg::board_cfg_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: board got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // bases sit at words 0 to 5 and scroll at 6 to 15 with star base 16 and control 17
    task automatic check_all();
        ppu_mmr_pkg::scroll_set_t es;
        ppu_mmr_pkg::vram_set_t   ev;
        ppu_mmr_pkg::prio_set_t   ep;
        ppu_mmr_pkg::board_cfg_t  eb;
        es = '{hpos1: m_cpsa[6], vpos1: m_cpsa[7], hpos2: m_cpsa[8], vpos2: m_cpsa[9],
               hpos3: m_cpsa[10], vpos3: m_cpsa[11], hstar1: m_cpsa[12],
               vstar1: m_cpsa[13], hstar2: m_cpsa[14], vstar2: m_cpsa[15]};
        ev = '{obj: m_cpsa[0], scr1: m_cpsa[1], scr2: m_cpsa[2], scr3: m_cpsa[3],
               row: m_cpsa[4], pal_base: m_cpsa[5], star: m_cpsa[16], ppu_ctrl: m_cpsa[17]};
        ep = '{layer_ctrl: m_layer, prio0: m_prio[0], prio1: m_prio[1], prio2: m_prio[2],
               prio3: m_prio[3], pal_page_en: m_pal_page};
        eb.layer_mask  = {m_cfg[15], m_cfg[14], m_cfg[13], m_cfg[12]};
        eb.game        = m_cfg[16][5:0];
        eb.bank_offset = {m_cfg[18], m_cfg[17]};
        eb.bank_mask   = {m_cfg[20], m_cfg[19]};
        check_scroll(scroll, es);
        check_vram(vram, ev);
        check_prio(prio, ep);
        check_board(board, eb);
        check_word(mmr_dout, m_dout, "mmr_dout");
        check_word({15'd0, pal_copy}, {15'd0, m_pal_copy}, "pal_copy");
    endtask

    // advance the model by one clock using the inputs driven now
    task automatic model_step();
        logic [31:0] next_product;
        logic [4:0]  a;
        a = bus.addr;
        next_product = {16'd0, m_mult1} * {16'd0, m_mult2};
        if (ppu2_cs) begin
            m_dout = read_value(a);
            if (bus.dsn == 2'b00 && a != 5'd31) begin
                for (int s = 0; s < 11; s++) begin
                    if (slot_addr(s) == a) begin
                        case (s)
                            1: m_mult1 = bus.data;
                            2: m_mult2 = bus.data;
                            5: m_layer = bus.data;
                            6, 7, 8, 9: m_prio[s - 6] = bus.data;
                            10: m_pal_page = bus.data[5:0];
                            default: ;
                        endcase
                    end
                end
            end
        end
        m_product = next_product;
        if (ppu1_cs && a <= 5'd17) begin
            if (!bus.dsn[1]) begin
                m_cpsa[a][15:8] = bus.data[15:8];
            end
            if (!bus.dsn[0]) begin
                m_cpsa[a][7:0] = bus.data[7:0];
            end
        end
        // palette copy fires on the first idle edge after a pal_base write
        m_pal_copy = m_armed && !ppu1_cs;
        m_armed = m_armed ? ppu1_cs : (ppu1_cs && a == 5'd5);
        if (cfg_we) begin
            for (int i = 20; i > 0; i--) begin
                m_cfg[i] = m_cfg[i - 1];
            end
            m_cfg[0] = cfg_data;
        end
    endtask

    task automatic cycle();
        model_step();
        @(posedge clk);
        @(negedge clk);
        if (pal_copy) begin
            pulse_count++;
        end
        check_all();
    endtask

    task automatic cpsa_write(input logic [4:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data, input int hold);
        ppu1_cs = 1'b1;
        bus = '{addr: addr, dsn: dsn, data: data};
        repeat (hold) begin
            cycle();
        end
        ppu1_cs = 1'b0;
        cycle();
    endtask

    task automatic cpsb_access(input logic [4:0] addr, input logic [1:0] dsn,
                               input logic [15:0] data);
        ppu2_cs = 1'b1;
        bus = '{addr: addr, dsn: dsn, data: data};
        cycle();
        ppu2_cs = 1'b0;
        cycle();
    endtask

    initial begin
        logic [7:0]  img [21];
        logic        used [32];
        logic [15:0] r;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [31:0] prod;
        int          k;
        reg_rst     = 1'b1;
        ppu1_cs     = 1'b0;
        ppu2_cs     = 1'b0;
        cfg_we      = 1'b0;
        cfg_data    = 8'h00;
        bus         = '0;
        rng_state   = 32'd83643;
        err_count   = 0;
        pulse_count = 0;
        foreach (m_cfg[i]) begin
            m_cfg[i] = 8'hff;
        end
        foreach (m_cpsa[i]) begin
            m_cpsa[i] = 16'h0000;
        end
        foreach (m_prio[i]) begin
            m_prio[i] = 16'hffff;
        end
        m_layer    = `MMR_LAYER_CTRL_RST;
        m_pal_page = 6'h3f;
        m_mult1    = 16'h0000;
        m_mult2    = 16'h0000;
        m_product  = 32'h0;
        m_dout     = 16'hffff;
        m_armed    = 1'b0;
        m_pal_copy = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reg_rst = 1'b0;

        // reset values and a read at 31 where every slot is parked
        check_all();
        cpsb_access(5'd31, 2'b11, 16'h0000);
        check_word(mmr_dout, 16'hffff, "readback after reset");

        // random board string with distinct slot addresses below 31
        foreach (used[i]) begin
            used[i] = 1'b0;
        end
        foreach (img[i]) begin
            r = lcg_next16();
            img[i] = r[7:0];
        end
        for (int s = 0; s < 11; s++) begin
            do begin
                r = lcg_next16();
            end while (r[4:0] == 5'd31 || used[r[4:0]]);
            used[r[4:0]] = 1'b1;
            slot_pick[s] = r[4:0];
            img[(s == 0) ? 0 : s + 1][5:1] = r[4:0];
        end
        // first byte written ends up in byte 20
        for (int i = 20; i >= 0; i--) begin
            cfg_we   = 1'b1;
            cfg_data = img[i];
            cycle();
        end
        cfg_we = 1'b0;
        cpsb_access(slot_pick[0], 2'b11, lcg_next16());
        check_word(mmr_dout, {4'h0, img[1][7:4], 4'h0, img[1][3:0]}, "board id");

        // every eighth cps-a write is aimed at pal_base
        for (int n = 0; n < N_CPSA; n++) begin
            r = lcg_next16();
            cpsa_write((r[2:0] == 3'd0) ? 5'd5 : r[7:3], r[9:8], lcg_next16(),
                       1 + int'(r[10]));
        end
        if (pulse_count == 0) begin
            $display("no palette copy pulse was seen during the cps-a writes");
            abort_run();
        end

        // half of the cps-b accesses go to mapped slots and half anywhere
        for (int n = 0; n < N_CPSB; n++) begin
            r = lcg_next16();
            k = int'(r[15:12]) % 11;
            cpsb_access(r[0] ? slot_pick[k] : r[5:1], r[7:6], lcg_next16());
        end

        // multiplier results are read after two idle cycles
        for (int n = 0; n < N_MULT; n++) begin
            op_a = lcg_next16();
            op_b = lcg_next16();
            cpsb_access(slot_pick[1], 2'b00, op_a);
            cpsb_access(slot_pick[2], 2'b00, op_b);
            cycle();
            prod = {16'd0, op_a} * {16'd0, op_b};
            cpsb_access(slot_pick[3], 2'b11, 16'h0000);
            check_word(mmr_dout, prod[15:0], "rslt0");
            cpsb_access(slot_pick[4], 2'b11, 16'h0000);
            check_word(mmr_dout, prod[31:16], "rslt1");
        end

        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== ppu_mmr.f ====
+incdir+include
src/ppu_mmr_pkg.sv
src/cpsb_map_loader.sv
src/cpsa_regs.sv
src/cpsb_regs.sv
src/ppu_mmr.sv
verification/ppu_mmr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the ppu_mmr testbench with verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module ppu_mmr_tb -f ppu_mmr.f -Mdir obj_dir -o ppu_mmr_sim

# tee decides the pipeline status, the log decides the verdict
./obj_dir/ppu_mmr_sim 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
